/* lite_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite crossbar shared types
// Widths, channel structs, request and response bundles
// and the address rule used by the decoders
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lite_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_decerr = 2'b11
  } resp_e;

  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_chan_t;

  // Manager to subordinate direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } lite_req_t;

  // Subordinate to manager direction
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } lite_resp_t;

  // Half-open range, start_addr <= addr < end_addr
  typedef struct packed {
    logic [7:0] idx;
    addr_t      start_addr;
    addr_t      end_addr;
  } addr_rule_t;

endpackage

/* lite_addr_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decoder
// Maps an address to a subordinate index via the rule table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lite_addr_decode import lite_pkg::*; #(
  parameter int unsigned NumSub   = 2,
  parameter int unsigned NumRules = 2,
  localparam int unsigned IdxWidth = (NumSub > 1) ? $clog2(NumSub) : 1
) (
  input  addr_t                     addr_i,
  input  addr_rule_t [NumRules-1:0] addr_map_i,
  input  logic                      en_default_i,
  input  logic [IdxWidth-1:0]       default_idx_i,
  output logic [IdxWidth-1:0]       idx_o,
  output logic                      dec_error_o
);

  logic matched;

  always_comb begin
    matched     = 1'b0;
    idx_o       = default_idx_i;
    dec_error_o = 1'b0;
    // Later rules override earlier ones
    for (int unsigned r = 0; r < NumRules; r++) begin
      if ((addr_i >= addr_map_i[r].start_addr) && (addr_i < addr_map_i[r].end_addr)) begin
        matched = 1'b1;
        idx_o   = addr_map_i[r].idx[IdxWidth-1:0];
      end
    end
    if (!matched && !en_default_i) begin
      dec_error_o = 1'b1; // Routed to the error responder
    end
  end

endmodule

/* lite_err_resp.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode error responder
// Answers every write and read with DECERR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lite_err_resp import lite_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  lite_req_t  req_i,
  output lite_resp_t resp_o
);

  logic aw_got_q, w_got_q, b_valid_q;
  logic r_valid_q;
  logic aw_fire, w_fire;

  always_comb begin
    resp_o          = '0;
    resp_o.aw_ready = !aw_got_q && !b_valid_q;
    resp_o.w_ready  = !w_got_q && !b_valid_q;
    resp_o.b.resp   = resp_decerr;
    resp_o.b_valid  = b_valid_q;
    resp_o.ar_ready = !r_valid_q;  // One read at a time
    resp_o.r.data   = '0;
    resp_o.r.resp   = resp_decerr;
    resp_o.r_valid  = r_valid_q;
  end

  assign aw_fire = req_i.aw_valid && resp_o.aw_ready;
  assign w_fire  = req_i.w_valid && resp_o.w_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      // AW and W in either order, B follows the later one
      if (b_valid_q) begin
        if (req_i.b_ready) begin
          b_valid_q <= 1'b0;
          aw_got_q  <= 1'b0;
          w_got_q   <= 1'b0;
        end
      end else if ((aw_got_q || aw_fire) && (w_got_q || w_fire)) begin
        b_valid_q <= 1'b1;
      end else begin
        aw_got_q <= aw_got_q || aw_fire;
        w_got_q  <= w_got_q || w_fire;
      end
      if (r_valid_q) r_valid_q <= !req_i.r_ready;
      else           r_valid_q <= req_i.ar_valid;
    end
  end

endmodule

/* lite_demux.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Manager-side demultiplexer
// Steers one manager onto a selected route and
// returns B and R from the route it recorded
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lite_demux import lite_pkg::*; #(
  parameter int unsigned NumRoutes = 3,
  localparam int unsigned SelWidth = (NumRoutes > 1) ? $clog2(NumRoutes) : 1
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  lite_req_t                   req_i,
  output lite_resp_t                  resp_o,
  input  logic [SelWidth-1:0]         aw_select_i,
  input  logic [SelWidth-1:0]         ar_select_i,
  output lite_req_t  [NumRoutes-1:0]  route_reqs_o,
  input  lite_resp_t [NumRoutes-1:0]  route_resps_i
);

  logic                w_busy_q, w_sent_q;
  logic [SelWidth-1:0] w_route_q;
  logic                r_busy_q;
  logic [SelWidth-1:0] r_route_q;

  always_comb begin
    // Payload fans out to every route, handshakes only to one
    for (int unsigned k = 0; k < NumRoutes; k++) begin
      route_reqs_o[k]          = req_i;
      route_reqs_o[k].aw_valid = 1'b0;
      route_reqs_o[k].w_valid  = 1'b0;
      route_reqs_o[k].b_ready  = 1'b0;
      route_reqs_o[k].ar_valid = 1'b0;
      route_reqs_o[k].r_ready  = 1'b0;
    end
    resp_o = '0;

    if (!w_busy_q) begin
      route_reqs_o[aw_select_i].aw_valid = req_i.aw_valid;
      resp_o.aw_ready = route_resps_i[aw_select_i].aw_ready;
    end else begin
      if (!w_sent_q) begin  // Single W beat per write
        route_reqs_o[w_route_q].w_valid = req_i.w_valid;
        resp_o.w_ready = route_resps_i[w_route_q].w_ready;
      end
      route_reqs_o[w_route_q].b_ready = req_i.b_ready;
      resp_o.b       = route_resps_i[w_route_q].b;
      resp_o.b_valid = route_resps_i[w_route_q].b_valid;
    end

    if (!r_busy_q) begin
      route_reqs_o[ar_select_i].ar_valid = req_i.ar_valid;
      resp_o.ar_ready = route_resps_i[ar_select_i].ar_ready;
    end else begin
      route_reqs_o[r_route_q].r_ready = req_i.r_ready;
      resp_o.r       = route_resps_i[r_route_q].r;
      resp_o.r_valid = route_resps_i[r_route_q].r_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_busy_q  <= 1'b0;
      w_sent_q  <= 1'b0;
      w_route_q <= '0;
      r_busy_q  <= 1'b0;
      r_route_q <= '0;
    end else begin
      if (req_i.aw_valid && resp_o.aw_ready) begin
        w_busy_q  <= 1'b1;
        w_sent_q  <= 1'b0;
        w_route_q <= aw_select_i;
      end
      if (req_i.w_valid && resp_o.w_ready) w_sent_q <= 1'b1;
      if (resp_o.b_valid && req_i.b_ready) w_busy_q <= 1'b0;  // Write slot free

      if (req_i.ar_valid && resp_o.ar_ready) begin
        r_busy_q  <= 1'b1;
        r_route_q <= ar_select_i;
      end
      if (resp_o.r_valid && req_i.r_ready) r_busy_q <= 1'b0;
    end
  end

endmodule

/* lite_mux.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subordinate-side multiplexer
// Round-robin arbitration of managers, with the
// response routed back to the locked manager
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lite_mux import lite_pkg::*; #(
  parameter int unsigned NumMgr = 2,
  localparam int unsigned IdxWidth = (NumMgr > 1) ? $clog2(NumMgr) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  lite_req_t  [NumMgr-1:0]  mgr_reqs_i,
  output lite_resp_t [NumMgr-1:0]  mgr_resps_o,
  output lite_req_t                sub_req_o,
  input  lite_resp_t               sub_resp_i
);

  typedef struct packed {
    logic                found;
    logic [IdxWidth-1:0] idx;
  } grant_t;

  // First requester at or after the priority pointer
  function automatic grant_t rr_pick(logic [NumMgr-1:0] reqs, logic [IdxWidth-1:0] prio);
    grant_t      pick;
    int unsigned cand;
    pick = '0;
    for (int unsigned k = 0; k < NumMgr; k++) begin
      cand = (prio + k) % NumMgr;
      if (!pick.found && reqs[cand]) pick = '{found: 1'b1, idx: IdxWidth'(cand)};
    end
    return pick;
  endfunction

  function automatic logic [IdxWidth-1:0] next_prio(logic [IdxWidth-1:0] idx);
    return (idx == IdxWidth'(NumMgr - 1)) ? '0 : idx + 1'b1;
  endfunction

  logic [NumMgr-1:0]   aw_reqs, ar_reqs;
  grant_t              aw_sel, ar_sel;
  logic                w_lock_q, w_pend_q, w_sent_q;
  logic [IdxWidth-1:0] w_idx_q, w_prio_q;
  logic                r_lock_q, r_pend_q;
  logic [IdxWidth-1:0] r_idx_q, r_prio_q;

  always_comb begin
    for (int unsigned i = 0; i < NumMgr; i++) begin
      aw_reqs[i] = mgr_reqs_i[i].aw_valid;
      ar_reqs[i] = mgr_reqs_i[i].ar_valid;
    end
    // A pending address keeps its grant until accepted
    aw_sel = w_pend_q ? grant_t'{found: 1'b1, idx: w_idx_q} : rr_pick(aw_reqs, w_prio_q);
    ar_sel = r_pend_q ? grant_t'{found: 1'b1, idx: r_idx_q} : rr_pick(ar_reqs, r_prio_q);

    sub_req_o    = '0;
    mgr_resps_o  = '0;
    sub_req_o.aw = mgr_reqs_i[aw_sel.idx].aw;
    sub_req_o.w  = mgr_reqs_i[w_idx_q].w;
    sub_req_o.ar = mgr_reqs_i[ar_sel.idx].ar;

    if (!w_lock_q) begin
      sub_req_o.aw_valid = aw_sel.found;
      mgr_resps_o[aw_sel.idx].aw_ready = aw_sel.found && sub_resp_i.aw_ready;
    end else begin
      if (!w_sent_q) begin
        sub_req_o.w_valid = mgr_reqs_i[w_idx_q].w_valid;
        mgr_resps_o[w_idx_q].w_ready = sub_resp_i.w_ready;
      end
      sub_req_o.b_ready = mgr_reqs_i[w_idx_q].b_ready;
      mgr_resps_o[w_idx_q].b       = sub_resp_i.b;
      mgr_resps_o[w_idx_q].b_valid = sub_resp_i.b_valid;
    end

    if (!r_lock_q) begin
      sub_req_o.ar_valid = ar_sel.found;
      mgr_resps_o[ar_sel.idx].ar_ready = ar_sel.found && sub_resp_i.ar_ready;
    end else begin
      sub_req_o.r_ready = mgr_reqs_i[r_idx_q].r_ready;
      mgr_resps_o[r_idx_q].r       = sub_resp_i.r;
      mgr_resps_o[r_idx_q].r_valid = sub_resp_i.r_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      {w_lock_q, w_pend_q, w_sent_q, w_idx_q, w_prio_q} <= '0;
      {r_lock_q, r_pend_q, r_idx_q, r_prio_q} <= '0;
    end else begin
      if (!w_lock_q && aw_sel.found) begin
        w_idx_q  <= aw_sel.idx;
        w_pend_q <= !sub_resp_i.aw_ready;
        if (sub_resp_i.aw_ready) begin  // Lock until B
          w_lock_q <= 1'b1;
          w_sent_q <= 1'b0;
          w_prio_q <= next_prio(aw_sel.idx);
        end
      end
      if (sub_req_o.w_valid && sub_resp_i.w_ready) w_sent_q <= 1'b1;
      if (sub_resp_i.b_valid && sub_req_o.b_ready) w_lock_q <= 1'b0;

      if (!r_lock_q && ar_sel.found) begin
        r_idx_q  <= ar_sel.idx;
        r_pend_q <= !sub_resp_i.ar_ready;
        if (sub_resp_i.ar_ready) begin
          r_lock_q <= 1'b1;
          r_prio_q <= next_prio(ar_sel.idx);
        end
      end
      if (sub_resp_i.r_valid && sub_req_o.r_ready) r_lock_q <= 1'b0;
    end
  end

endmodule

/* lite_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite crossbar top level
// Per-manager decode and demux, per-subordinate mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module lite_xbar import lite_pkg::*; #(
  parameter int unsigned NumMgr   = 2,
  parameter int unsigned NumSub   = 2,
  parameter int unsigned NumRules = 2,
  localparam int unsigned SubIdxWidth = (NumSub > 1) ? $clog2(NumSub) : 1,
  localparam int unsigned RouteWidth  = $clog2(NumSub + 1)
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  lite_req_t  [NumMgr-1:0]                mgr_reqs_i,
  output lite_resp_t [NumMgr-1:0]                mgr_resps_o,
  output lite_req_t  [NumSub-1:0]                sub_reqs_o,
  input  lite_resp_t [NumSub-1:0]                sub_resps_i,
  input  addr_rule_t [NumRules-1:0]              addr_map_i,
  input  logic       [NumMgr-1:0]                en_default_i,
  input  logic       [NumMgr-1:0][SubIdxWidth-1:0] default_idx_i
);

  // Demux side, extra route NumSub for decode errors
  lite_req_t  [NumMgr-1:0][NumSub:0] route_reqs;
  lite_resp_t [NumMgr-1:0][NumSub:0] route_resps;
  // Mux side, indexed by subordinate then manager
  lite_req_t  [NumSub-1:0][NumMgr-1:0] cross_reqs;
  lite_resp_t [NumSub-1:0][NumMgr-1:0] cross_resps;

  for (genvar i = 0; i < NumMgr; i++) begin : gen_mgr
    logic [SubIdxWidth-1:0] dec_aw, dec_ar;
    logic                   dec_aw_error, dec_ar_error;
    logic [RouteWidth-1:0]  aw_select, ar_select;

    lite_addr_decode #(.NumSub(NumSub), .NumRules(NumRules)) i_aw_decode (
      .addr_i       (mgr_reqs_i[i].aw.addr),
      .addr_map_i   (addr_map_i),
      .en_default_i (en_default_i[i]),
      .default_idx_i(default_idx_i[i]),
      .idx_o        (dec_aw),
      .dec_error_o  (dec_aw_error)
    );

    lite_addr_decode #(.NumSub(NumSub), .NumRules(NumRules)) i_ar_decode (
      .addr_i       (mgr_reqs_i[i].ar.addr),
      .addr_map_i   (addr_map_i),
      .en_default_i (en_default_i[i]),
      .default_idx_i(default_idx_i[i]),
      .idx_o        (dec_ar),
      .dec_error_o  (dec_ar_error)
    );

    assign aw_select = dec_aw_error ? RouteWidth'(NumSub) : RouteWidth'(dec_aw);
    assign ar_select = dec_ar_error ? RouteWidth'(NumSub) : RouteWidth'(dec_ar);

    lite_demux #(.NumRoutes(NumSub + 1)) i_demux (
      .clk_i, .rst_i,
      .req_i        (mgr_reqs_i[i]),
      .resp_o       (mgr_resps_o[i]),
      .aw_select_i  (aw_select),
      .ar_select_i  (ar_select),
      .route_reqs_o (route_reqs[i]),
      .route_resps_i(route_resps[i])
    );

    lite_err_resp i_err_resp (
      .clk_i, .rst_i,
      .req_i (route_reqs[i][NumSub]),
      .resp_o(route_resps[i][NumSub])
    );
  end

  for (genvar i = 0; i < NumMgr; i++) begin : gen_cross_mgr
    for (genvar j = 0; j < NumSub; j++) begin : gen_cross_sub
      assign cross_reqs[j][i]  = route_reqs[i][j];
      assign route_resps[i][j] = cross_resps[j][i];
    end
  end

  for (genvar j = 0; j < NumSub; j++) begin : gen_sub
    lite_mux #(.NumMgr(NumMgr)) i_mux (
      .clk_i, .rst_i,
      .mgr_reqs_i (cross_reqs[j]),
      .mgr_resps_o(cross_resps[j]),
      .sub_req_o  (sub_reqs_o[j]),
      .sub_resp_i (sub_resps_i[j])
    );
  end

endmodule

/* tb_clk_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator
// 10 ns clock, reset high for ResetCycles edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_o <= 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    rst_o <= 1'b0;  // Released on a rising edge
  end

endmodule

/* tb_lite_xbar.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite crossbar testbench
// Two managers run a stimulus table against two
// subordinate memory models with random ready delays
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_lite_xbar import lite_pkg::*; ();

  localparam int unsigned TimeoutCycles = 64;
  localparam int unsigned NumEntries    = 11;

  typedef struct packed {
    logic  mgr;
    logic  write;
    addr_t addr;
    data_t data;
    strb_t strb;
    logic  en_def;
    logic  def_idx;
    data_t exp_data;
    resp_e exp_resp;
  } entry_t;

  logic             clk;
  logic             rst;
  lite_req_t  [1:0] mgr_reqs;
  lite_resp_t [1:0] mgr_resps;
  lite_req_t  [1:0] sub_reqs;
  lite_resp_t [1:0] sub_resps;
  addr_rule_t [1:0] addr_map;
  logic [1:0]       en_default = '0;
  logic [1:0][0:0]  default_idx = '0;

  lite_req_t  mgr_req_q [2] = '{'0, '0};
  lite_resp_t sub_resp_q [2] = '{'0, '0};

  // Subordinate model state
  data_t       mem [2][16];
  logic        aw_got [2];
  logic        w_got [2];
  logic [3:0]  waddr [2];
  w_chan_t     wbeat [2];
  logic [1:0]  aw_wait [2];
  logic [1:0]  w_wait [2];
  logic [1:0]  ar_wait [2];
  int          aw_cnt [2];
  int          ar_cnt [2];
  logic [31:0] lfsr_state = 32'h881a_8c4c;
  bit          rand_en = 1'b0;
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;

  entry_t stim_table [NumEntries] = '{
    // Full word then bytes 0 and 2 replaced and read back by the other manager
    '{1'b0, 1'b1, 32'h0000_0004, 32'h1111_2222, 4'hf, 1'b0, 1'b0, 32'h0, resp_okay},
    '{1'b0, 1'b1, 32'h0000_0004, 32'haabb_ccdd, 4'h5, 1'b0, 1'b0, 32'h0, resp_okay},
    '{1'b1, 1'b0, 32'h0000_0004, 32'h0, 4'h0, 1'b0, 1'b0, 32'h11bb_22dd, resp_okay},
    '{1'b0, 1'b1, 32'h0001_0010, 32'h3333_4444, 4'hf, 1'b0, 1'b0, 32'h0, resp_okay},
    '{1'b0, 1'b1, 32'h0001_0010, 32'h5566_7788, 4'h8, 1'b0, 1'b0, 32'h0, resp_okay},
    '{1'b1, 1'b0, 32'h0001_0010, 32'h0, 4'h0, 1'b0, 1'b0, 32'h5533_4444, resp_okay},
    // Unmapped with the default off
    '{1'b1, 1'b1, 32'h0000_2000, 32'hdead_0001, 4'hf, 1'b0, 1'b0, 32'h0, resp_decerr},
    '{1'b0, 1'b0, 32'h0003_0000, 32'h0, 4'h0, 1'b0, 1'b0, 32'h0, resp_decerr},
    // Unmapped with default port 1 lands on word 2 of subordinate 1
    '{1'b0, 1'b1, 32'h0002_0008, 32'h9abc_def0, 4'hf, 1'b1, 1'b1, 32'h0, resp_okay},
    '{1'b1, 1'b0, 32'h0001_0008, 32'h0, 4'h0, 1'b0, 1'b0, 32'h9abc_def0, resp_okay},
    '{1'b1, 1'b0, 32'h0002_0008, 32'h0, 4'h0, 1'b1, 1'b1, 32'h9abc_def0, resp_okay}
  };

  tb_clk_gen #(.ResetCycles(4)) i_clk_gen (
    .clk_o(clk),
    .rst_o(rst)
  );

  lite_xbar #(.NumMgr(2), .NumSub(2), .NumRules(2)) i_lite_xbar (
    .clk_i        (clk),
    .rst_i        (rst),
    .mgr_reqs_i   (mgr_reqs),
    .mgr_resps_o  (mgr_resps),
    .sub_reqs_o   (sub_reqs),
    .sub_resps_i  (sub_resps),
    .addr_map_i   (addr_map),
    .en_default_i (en_default),
    .default_idx_i(default_idx)
  );

  assign mgr_reqs    = {mgr_req_q[1], mgr_req_q[0]};
  assign sub_resps   = {sub_resp_q[1], sub_resp_q[0]};
  assign addr_map[0] = '{idx: 8'd0, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000};
  assign addr_map[1] = '{idx: 8'd1, start_addr: 32'h0001_0000, end_addr: 32'h0001_1000};

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task draw_delay(output logic [1:0] delay);
    delay = '0;
    if (rand_en) begin
      for (int b = 0; b < 2; b++) begin
        lfsr_state = lfsr_next(lfsr_state);
        delay[b]   = lfsr_state[0];
      end
    end
  endtask

  // Both subordinate models draw from one LFSR in a fixed order
  always @(posedge clk) begin : sub_model
    logic [1:0] delay;
    for (int j = 0; j < 2; j++) begin
      if (rst) begin
        sub_resp_q[j] <= '0;
        aw_got[j]     <= 1'b0;
        w_got[j]      <= 1'b0;
        aw_wait[j]    <= '0;
        w_wait[j]     <= '0;
        ar_wait[j]    <= '0;
        aw_cnt[j]     <= 0;
        ar_cnt[j]     <= 0;
        for (int k = 0; k < 16; k++) begin
          mem[j][k] <= 32'h5a00_0000 | 32'(j << 8) | 32'(k);
        end
      end else begin
        if (sub_reqs[j].aw_valid && sub_resp_q[j].aw_ready) begin
          sub_resp_q[j].aw_ready <= 1'b0;
          aw_got[j] <= 1'b1;
          waddr[j]  <= sub_reqs[j].aw.addr[5:2];
          aw_cnt[j] <= aw_cnt[j] + 1;
          draw_delay(delay);
          aw_wait[j] <= delay;
        end else if (!aw_got[j] && !sub_resp_q[j].aw_ready) begin
          if (aw_wait[j] == 2'd0) sub_resp_q[j].aw_ready <= 1'b1;
          else aw_wait[j] <= aw_wait[j] - 2'd1;
        end

        if (sub_reqs[j].w_valid && sub_resp_q[j].w_ready) begin
          sub_resp_q[j].w_ready <= 1'b0;
          w_got[j] <= 1'b1;
          wbeat[j] <= sub_reqs[j].w;
          draw_delay(delay);
          w_wait[j] <= delay;
        end else if (!w_got[j] && !sub_resp_q[j].w_ready) begin
          if (w_wait[j] == 2'd0) sub_resp_q[j].w_ready <= 1'b1;
          else w_wait[j] <= w_wait[j] - 2'd1;
        end

        if (aw_got[j] && w_got[j] && !sub_resp_q[j].b_valid) begin
          sub_resp_q[j].b_valid <= 1'b1;
          for (int b = 0; b < 4; b++) begin  // Byte lanes merged by strobe
            if (wbeat[j].strb[b]) mem[j][waddr[j]][8*b +: 8] <= wbeat[j].data[8*b +: 8];
          end
        end else if (sub_resp_q[j].b_valid && sub_reqs[j].b_ready) begin
          sub_resp_q[j].b_valid <= 1'b0;
          aw_got[j] <= 1'b0;
          w_got[j]  <= 1'b0;
        end

        if (sub_reqs[j].ar_valid && sub_resp_q[j].ar_ready) begin
          sub_resp_q[j].ar_ready <= 1'b0;
          sub_resp_q[j].r_valid  <= 1'b1;
          sub_resp_q[j].r.data   <= mem[j][sub_reqs[j].ar.addr[5:2]];
          ar_cnt[j] <= ar_cnt[j] + 1;
          draw_delay(delay);
          ar_wait[j] <= delay;
        end else if (sub_resp_q[j].r_valid) begin
          if (sub_reqs[j].r_ready) sub_resp_q[j].r_valid <= 1'b0;
        end else if (!sub_resp_q[j].ar_ready) begin
          if (ar_wait[j] == 2'd0) sub_resp_q[j].ar_ready <= 1'b1;
          else ar_wait[j] <= ar_wait[j] - 2'd1;
        end
      end
    end
  end

  function automatic int total_hits();
    return aw_cnt[0] + aw_cnt[1] + ar_cnt[0] + ar_cnt[1];
  endfunction

  task automatic check_b(b_chan_t got, b_chan_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s B resp %b, expected %b", $time, what, got.resp, exp.resp);
    end
  endtask

  task automatic check_r(r_chan_t got, r_chan_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s R data %h resp %b, expected data %h resp %b",
               $time, what, got.data, got.resp, exp.data, exp.resp);
    end
  endtask

  task automatic compare_count(int got, int exp, string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR at %0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic expect_idle(lite_req_t [1:0] reqs, lite_resp_t [1:0] resps);
    for (int k = 0; k < 2; k++) begin
      checks++;
      if ({reqs[k].aw_valid, reqs[k].w_valid, reqs[k].ar_valid,
           resps[k].b_valid, resps[k].r_valid} !== 5'b0) begin
        errors++;
        $display("ERROR at %0t: valid high on port %0d after reset", $time, k);
      end
    end
  endtask

  task automatic write_txn(int m, addr_t addr, data_t data, strb_t strb, output b_chan_t b);
    bit aw_pend;
    bit w_pend;
    bit aw_fire;
    bit w_fire;
    bit b_fire;
    int n;
    b = '0;
    @(posedge clk);
    mgr_req_q[m].aw       <= '{addr: addr};
    mgr_req_q[m].aw_valid <= 1'b1;
    mgr_req_q[m].w        <= '{data: data, strb: strb};
    mgr_req_q[m].w_valid  <= 1'b1;
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    n = 0;
    while ((aw_pend || w_pend) && n < TimeoutCycles) begin
      @(negedge clk);  // Ready is settled before the coming edge
      aw_fire = aw_pend && mgr_resps[m].aw_ready;
      w_fire  = w_pend && mgr_resps[m].w_ready;
      @(posedge clk);
      if (aw_fire) mgr_req_q[m].aw_valid <= 1'b0;
      if (w_fire) mgr_req_q[m].w_valid <= 1'b0;
      aw_pend = aw_pend && !aw_fire;
      w_pend  = w_pend && !w_fire;
      n++;
    end
    if (aw_pend || w_pend) begin
      timeouts++;
      $display("Timeout: manager %0d write to %h was never accepted", m, addr);
      return;
    end
    mgr_req_q[m].b_ready <= 1'b1;
    b_fire = 1'b0;
    n = 0;
    while (!b_fire && n < TimeoutCycles) begin
      @(negedge clk);
      b_fire = mgr_resps[m].b_valid;
      b      = mgr_resps[m].b;
      @(posedge clk);
      n++;
    end
    mgr_req_q[m].b_ready <= 1'b0;
    if (!b_fire) begin
      timeouts++;
      $display("Timeout: manager %0d got no write response for %h", m, addr);
    end
  endtask

  task automatic read_txn(int m, addr_t addr, output r_chan_t r);
    bit fire;
    int n;
    r = '0;
    @(posedge clk);
    mgr_req_q[m].ar       <= '{addr: addr};
    mgr_req_q[m].ar_valid <= 1'b1;
    fire = 1'b0;
    n = 0;
    while (!fire && n < TimeoutCycles) begin
      @(negedge clk);
      fire = mgr_resps[m].ar_ready;
      @(posedge clk);
      n++;
    end
    mgr_req_q[m].ar_valid <= 1'b0;
    if (!fire) begin
      timeouts++;
      $display("Timeout: manager %0d read of %h was never accepted", m, addr);
      return;
    end
    mgr_req_q[m].r_ready <= 1'b1;
    fire = 1'b0;
    n = 0;
    while (!fire && n < TimeoutCycles) begin
      @(negedge clk);
      fire = mgr_resps[m].r_valid;
      r    = mgr_resps[m].r;
      @(posedge clk);
      n++;
    end
    mgr_req_q[m].r_ready <= 1'b0;
    if (!fire) begin
      timeouts++;
      $display("Timeout: manager %0d got no read data for %h", m, addr);
    end
  endtask

  task automatic apply_entry(int idx, data_t flip);
    entry_t  e;
    b_chan_t b;
    r_chan_t r;
    int      hits_before;
    string   what;
    e    = stim_table[idx];
    what = $sformatf("entry %0d", idx);
    // Written and expected data inverted on the second pass
    e.data = e.data ^ flip;
    if (e.exp_resp == resp_okay) e.exp_data = e.exp_data ^ flip;
    @(posedge clk);
    en_default[e.mgr]  <= e.en_def;
    default_idx[e.mgr] <= e.def_idx;
    hits_before = total_hits();
    if (e.write) write_txn(int'(e.mgr), e.addr, e.data, e.strb, b);
    else read_txn(int'(e.mgr), e.addr, r);
    if (timeouts != 0) return;
    if (e.write) check_b(b, '{resp: e.exp_resp}, what);
    else check_r(r, '{data: e.exp_data, resp: e.exp_resp}, what);
    // Decode errors never reach a subordinate
    compare_count(total_hits() - hits_before, (e.exp_resp == resp_okay) ? 1 : 0, what);
  endtask

  // Same cycle writes to subordinate 0 in either grant order
  task automatic parallel_writes(data_t flip);
    b_chan_t b0;
    b_chan_t b1;
    r_chan_t r0;
    r_chan_t r1;
    @(posedge clk);
    en_default <= '0;
    fork
      write_txn(0, 32'h0000_0020, 32'hcafe_0000 ^ flip, 4'hf, b0);
      write_txn(1, 32'h0000_0024, 32'hbeef_0001 ^ flip, 4'hf, b1);
    join
    if (timeouts != 0) return;
    check_b(b0, '{resp: resp_okay}, "parallel write 0");
    check_b(b1, '{resp: resp_okay}, "parallel write 1");
    read_txn(1, 32'h0000_0020, r0);
    read_txn(0, 32'h0000_0024, r1);
    if (timeouts != 0) return;
    check_r(r0, '{data: 32'hcafe_0000 ^ flip, resp: resp_okay}, "parallel read 0");
    check_r(r1, '{data: 32'hbeef_0001 ^ flip, resp: resp_okay}, "parallel read 1");
  endtask

  initial begin : stimulus
    int    n;
    data_t flip;
    n = 0;
    while (rst !== 1'b0 && n < TimeoutCycles) begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end else begin
      @(negedge clk);
      expect_idle(sub_reqs, mgr_resps);
      // First pass with ready at once and second with random delays
      for (int pass = 0; pass < 2; pass++) begin
        @(posedge clk);
        rand_en <= (pass == 1);
        flip = (pass == 1) ? 32'hffff_ffff : 32'h0000_0000;
        for (int e = 0; e < NumEntries; e++) begin
          if (timeouts == 0) apply_entry(e, flip);
        end
        if (timeouts == 0) parallel_writes(flip);
      end
    end
    $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* files.f */
lite_pkg.sv
lite_addr_decode.sv
lite_err_resp.sv
lite_demux.sv
lite_mux.sv
lite_xbar.sv
tb_clk_gen.sv
tb_lite_xbar.sv

/* run_sim.sh */
#!/bin/sh
# Builds the crossbar testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" \
  && verilator --binary -j 0 --top-module tb_lite_xbar -f files.f -o sim_lite_xbar \
  && out="$(./obj_dir/sim_lite_xbar)" \
  && printf '%s\n' "$out" \
  && printf '%s\n' "$out" | grep -qx "Finished with no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
